// ==== build.f ====
common/rp_sample_pkg.sv
common/rp_ctrl_pkg.sv
hw/adc_frontend.sv
capture/capture_buffer.sv
hw/dac_output.sv
hw/pdm_dac.sv
hw/rp_top.sv
verification/rp_top_assertions.sv
verification/rp_top_tb.sv

// ==== capture/capture_buffer.sv ====
////////////////////
// capture buffer
// arm, acquire and done sequence that fills
// a per channel sample memory, with a
// registered read port by address
////////////////////

`timescale 1ns/1ps

module capture_buffer (
  input  logic                                                       adc_clk,
  input  logic                                                       top_rst,
  // sample stream, one sample per channel each cycle
  input  rp_sample_pkg::adc_sample_t [rp_sample_pkg::NUM_ADC_CH-1:0] samp_i,
  // start of a capture
  input  logic                                                       arm_i,
  // readout
  input  logic                                                       rd_ch_i,
  input  logic [rp_ctrl_pkg::CAP_AW-1:0]                             rd_addr_i,
  output rp_sample_pkg::adc_sample_t                                 rd_dat_o,
  // capture complete
  output logic                                                       done_o
);

  ////////////////////
  // control
  ////////////////////

  rp_ctrl_pkg::cap_state_e         state_q;
  logic [rp_ctrl_pkg::CAP_AW-1:0]  waddr_q;
  logic                            wr_en;
  logic                            wr_last;

  // write every cycle while acquiring
  assign wr_en   = (state_q == rp_ctrl_pkg::CAP_ACQ);
  // last address of the capture
  assign wr_last = (int'(waddr_q) == rp_ctrl_pkg::CAP_DEPTH - 1);

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q <= rp_ctrl_pkg::CAP_IDLE;
      waddr_q <= '0;
    end else begin
      case (state_q)
        rp_ctrl_pkg::CAP_IDLE,
        rp_ctrl_pkg::CAP_DONE: begin
          // arm restarts from address zero
          if (arm_i) begin
            state_q <= rp_ctrl_pkg::CAP_ACQ;
            waddr_q <= '0;
          end
        end
        rp_ctrl_pkg::CAP_ACQ: begin
          // arm is ignored here
          waddr_q <= waddr_q + 1'b1;
          if (wr_last) begin
            state_q <= rp_ctrl_pkg::CAP_DONE;
          end
        end
        default: begin
          state_q <= rp_ctrl_pkg::CAP_IDLE;
        end
      endcase
    end
  end

  // high from the cycle after the last write until the next arm
  assign done_o = (state_q == rp_ctrl_pkg::CAP_DONE);

  ////////////////////
  // sample memory
  ////////////////////

  rp_sample_pkg::adc_sample_t mem [rp_sample_pkg::NUM_ADC_CH][rp_ctrl_pkg::CAP_DEPTH];

  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      for (int c = 0; c < rp_sample_pkg::NUM_ADC_CH; c++) begin
        mem[c][waddr_q] <= samp_i[c];
      end
    end
  end

  // one cycle read latency
  always_ff @(posedge adc_clk) begin
    rd_dat_o <= mem[rd_ch_i][rd_addr_i];
  end

endmodule : capture_buffer

// ==== common/rp_ctrl_pkg.sv ====
////////////////////
// control package
// loop select and capture state encodings,
// capture depth and PDM constants
////////////////////

package rp_ctrl_pkg;

  // per channel source of the capture stream
  typedef enum logic {
    LOOP_ADC = 1'b0,
    LOOP_GEN = 1'b1
  } loop_sel_e;

  // capture sequence
  typedef enum logic [1:0] {
    CAP_IDLE = 2'd0,
    CAP_ACQ  = 2'd1,
    CAP_DONE = 2'd2
  } cap_state_e;

  // samples per channel and matching address width
  localparam int unsigned CAP_DEPTH = 32;
  localparam int unsigned CAP_AW    = 5;

  // PDM outputs
  localparam int unsigned      PDM_CHN   = 4;
  localparam int unsigned      PDM_W     = 8;
  localparam logic [PDM_W-1:0] PDM_RANGE = 8'd255;

endpackage : rp_ctrl_pkg

// ==== common/rp_sample_pkg.sv ====
////////////////////
// sample package
// widths, sample types and channel counts
// of the analog data path
////////////////////

package rp_sample_pkg;

  ////////////////////
  // channel counts
  ////////////////////

  // two ADC inputs on the board
  localparam int unsigned NUM_ADC_CH = 2;
  // two generator channels on one DAC bus
  localparam int unsigned NUM_DAC_CH = 2;

  ////////////////////
  // sample widths
  ////////////////////

  // ADC word, lowest bits unused on 14-bit parts
  localparam int unsigned ADC_W = 16;
  // DAC word
  localparam int unsigned DAC_W = 14;
  // generator to ADC scale in the loop path
  localparam int unsigned LOOP_SHIFT = 2;

  // two's complement samples
  typedef logic signed [ADC_W-1:0] adc_sample_t;
  typedef logic signed [DAC_W-1:0] dac_sample_t;

  // offset midscale, zero output voltage
  localparam logic [DAC_W-1:0] DAC_RESET_CODE = {1'b0, {(DAC_W-1){1'b1}}};

endpackage : rp_sample_pkg

// ==== hw/adc_frontend.sv ====
////////////////////
// ADC front end
// registers the ADC words, converts the
// negative slope offset code to two's
// complement and selects the loop source
////////////////////

`timescale 1ns/1ps

module adc_frontend (
  input  logic                                                      adc_clk,
  input  logic                                                      top_rst,
  // raw ADC words
  input  logic [rp_sample_pkg::NUM_ADC_CH-1:0][rp_sample_pkg::ADC_W-1:0] adc_dat_i,
  // generator samples for the loop path
  input  logic [rp_sample_pkg::NUM_DAC_CH-1:0][rp_sample_pkg::DAC_W-1:0] gen_dat_i,
  // per channel loop select
  input  logic [rp_sample_pkg::NUM_ADC_CH-1:0]                      loop_sel_i,
  // converted sample stream, valid every cycle
  output rp_sample_pkg::adc_sample_t [rp_sample_pkg::NUM_ADC_CH-1:0] samp_o
);

  ////////////////////
  // input registers
  ////////////////////

  // raw pin words, kept as offset code
  logic [rp_sample_pkg::ADC_W-1:0] adc_raw [rp_sample_pkg::NUM_ADC_CH];
  // generator words
  rp_sample_pkg::dac_sample_t      gen_q   [rp_sample_pkg::NUM_DAC_CH];
  // loop select, aligned with the data stage
  rp_ctrl_pkg::loop_sel_e          loop_q  [rp_sample_pkg::NUM_ADC_CH];

  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < rp_sample_pkg::NUM_ADC_CH; c++) begin
      adc_raw[c] <= adc_dat_i[c];
    end
    for (int c = 0; c < rp_sample_pkg::NUM_DAC_CH; c++) begin
      gen_q[c] <= gen_dat_i[c];
    end
  end

  ////////////////////
  // convert and select
  ////////////////////

  for (genvar i = 0; i < rp_sample_pkg::NUM_ADC_CH; i++) begin : g_ch
    rp_sample_pkg::adc_sample_t adc_conv;
    rp_sample_pkg::adc_sample_t gen_scaled;

    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        loop_q[i] <= rp_ctrl_pkg::LOOP_ADC;
      end else begin
        loop_q[i] <= rp_ctrl_pkg::loop_sel_e'(loop_sel_i[i]);
      end
    end

    // negative slope, keep sign bit and flip the rest
    assign adc_conv = {adc_raw[i][rp_sample_pkg::ADC_W-1], ~adc_raw[i][rp_sample_pkg::ADC_W-2:0]};

    // sign extend to ADC width, then scale up
    assign gen_scaled = {{(rp_sample_pkg::ADC_W - rp_sample_pkg::DAC_W){gen_q[i][rp_sample_pkg::DAC_W-1]}},
                         gen_q[i]} << rp_sample_pkg::LOOP_SHIFT;

    // second stage, selected sample
    always_ff @(posedge adc_clk) begin
      if (loop_q[i] == rp_ctrl_pkg::LOOP_GEN) begin
        samp_o[i] <= gen_scaled;
      end else begin
        samp_o[i] <= adc_conv;
      end
    end
  end : g_ch

endmodule : adc_frontend

// ==== hw/dac_output.sv ====
////////////////////
// DAC output
// registers the generator samples, converts
// them to offset code and interleaves both
// channels on one bus
////////////////////

`timescale 1ns/1ps

module dac_output (
  input  logic                                                      adc_clk,
  input  logic                                                      top_rst,
  // generator samples, two's complement
  input  logic [rp_sample_pkg::NUM_DAC_CH-1:0][rp_sample_pkg::DAC_W-1:0] gen_dat_i,
  // interleaved DAC bus
  output logic [rp_sample_pkg::DAC_W-1:0]                           dac_dat_o,
  // low for channel 0, high for channel 1
  output logic                                                      dac_sel_o
);

  ////////////////////
  // sample registers
  ////////////////////

  rp_sample_pkg::dac_sample_t       gen_q    [rp_sample_pkg::NUM_DAC_CH];
  logic [rp_sample_pkg::DAC_W-1:0]  dac_code [rp_sample_pkg::NUM_DAC_CH];
  logic                             sel_nxt;

  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < rp_sample_pkg::NUM_DAC_CH; c++) begin
      gen_q[c] <= gen_dat_i[c];
    end
  end

  // offset code with negative slope
  for (genvar i = 0; i < rp_sample_pkg::NUM_DAC_CH; i++) begin : g_code
    assign dac_code[i] = {gen_q[i][rp_sample_pkg::DAC_W-1], ~gen_q[i][rp_sample_pkg::DAC_W-2:0]};
  end : g_code

  ////////////////////
  // interleave
  ////////////////////

  // select for the coming cycle
  assign sel_nxt = ~dac_sel_o;

  // bus data follows the select on the same edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= rp_sample_pkg::DAC_RESET_CODE;
    end else begin
      dac_sel_o <= sel_nxt;
      dac_dat_o <= dac_code[sel_nxt];
    end
  end

endmodule : dac_output

// ==== hw/pdm_dac.sv ====
////////////////////
// PDM DAC
// first order pulse density modulators
// with a fixed range of 255
////////////////////

`timescale 1ns/1ps

module pdm_dac (
  input  logic                                                        adc_clk,
  input  logic                                                        top_rst,
  // output levels, 0 to 255
  input  logic [rp_ctrl_pkg::PDM_CHN-1:0][rp_ctrl_pkg::PDM_W-1:0]     pdm_lvl_i,
  // pulse outputs
  output logic [rp_ctrl_pkg::PDM_CHN-1:0]                             pdm_o
);

  for (genvar i = 0; i < rp_ctrl_pkg::PDM_CHN; i++) begin : g_ch
    // accumulator stays below the range
    logic [rp_ctrl_pkg::PDM_W-1:0] acc_q;
    // one extra bit for the carry
    logic [rp_ctrl_pkg::PDM_W:0]   sum;
    logic [rp_ctrl_pkg::PDM_W:0]   sub;
    logic                          hit;

    assign sum = {1'b0, acc_q} + {1'b0, pdm_lvl_i[i]};
    assign sub = sum - {1'b0, rp_ctrl_pkg::PDM_RANGE};
    // sum reached the range, emit a pulse
    assign hit = (sum >= {1'b0, rp_ctrl_pkg::PDM_RANGE});

    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        acc_q    <= '0;
        pdm_o[i] <= 1'b0;
      end else begin
        pdm_o[i] <= hit;
        // wrap by the range, not by 256
        if (hit) begin
          acc_q <= sub[rp_ctrl_pkg::PDM_W-1:0];
        end else begin
          acc_q <= sum[rp_ctrl_pkg::PDM_W-1:0];
        end
      end
    end
  end : g_ch

endmodule : pdm_dac

// ==== hw/rp_top.sv ====
////////////////////
// board top level
// ADC capture path, DAC interleave and
// PDM outputs in the ADC clock domain
////////////////////

`timescale 1ns/1ps

module rp_top (
  input  logic                                                          adc_clk,
  input  logic                                                          top_rst,
  // ADC pins
  input  logic [rp_sample_pkg::NUM_ADC_CH-1:0][rp_sample_pkg::ADC_W-1:0] adc_dat_i,
  // generator samples
  input  logic [rp_sample_pkg::NUM_DAC_CH-1:0][rp_sample_pkg::DAC_W-1:0] gen_dat_i,
  // per channel DAC to ADC loop
  input  logic [rp_sample_pkg::NUM_ADC_CH-1:0]                          loop_sel_i,
  // capture control and readout
  input  logic                                                          arm_i,
  input  logic                                                          rd_ch_i,
  input  logic [rp_ctrl_pkg::CAP_AW-1:0]                                rd_addr_i,
  output rp_sample_pkg::adc_sample_t                                    rd_dat_o,
  output logic                                                          done_o,
  // DAC pins
  output logic [rp_sample_pkg::DAC_W-1:0]                               dac_dat_o,
  output logic                                                          dac_sel_o,
  // PDM levels and outputs
  input  logic [rp_ctrl_pkg::PDM_CHN-1:0][rp_ctrl_pkg::PDM_W-1:0]       pdm_lvl_i,
  output logic [rp_ctrl_pkg::PDM_CHN-1:0]                               pdm_o
);

  ////////////////////
  // ADC capture path
  ////////////////////

  // converted samples into the capture memory
  rp_sample_pkg::adc_sample_t [rp_sample_pkg::NUM_ADC_CH-1:0] samp;

  adc_frontend u_adc_frontend (
    .adc_clk    (adc_clk   ),
    .top_rst    (top_rst   ),
    .adc_dat_i  (adc_dat_i ),
    .gen_dat_i  (gen_dat_i ),
    .loop_sel_i (loop_sel_i),
    .samp_o     (samp      )
  );

  capture_buffer u_capture_buffer (
    .adc_clk    (adc_clk   ),
    .top_rst    (top_rst   ),
    .samp_i     (samp      ),
    .arm_i      (arm_i     ),
    .rd_ch_i    (rd_ch_i   ),
    .rd_addr_i  (rd_addr_i ),
    .rd_dat_o   (rd_dat_o  ),
    .done_o     (done_o    )
  );

  ////////////////////
  // DAC and PDM
  ////////////////////

  // single rate interleave, one channel per cycle
  dac_output u_dac_output (
    .adc_clk    (adc_clk   ),
    .top_rst    (top_rst   ),
    .gen_dat_i  (gen_dat_i ),
    .dac_dat_o  (dac_dat_o ),
    .dac_sel_o  (dac_sel_o )
  );

  pdm_dac u_pdm_dac (
    .adc_clk    (adc_clk   ),
    .top_rst    (top_rst   ),
    .pdm_lvl_i  (pdm_lvl_i ),
    .pdm_o      (pdm_o     )
  );

endmodule : rp_top

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
# exit status is non-zero when the run fails
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module rp_top_tb -o rp_top_tb_sim &&
  ./obj_dir/rp_top_tb_sim ||
  exit 1

// ==== verification/rp_top_assertions.sv ====
////////////////////
// top level assertions
// DAC select toggle, done release
// and DAC reset code
////////////////////

`timescale 1ns/1ps

module rp_top_assertions (
  input logic                            adc_clk,
  input logic                            top_rst,
  input logic                            arm_i,
  input logic                            done_o,
  input logic [rp_sample_pkg::DAC_W-1:0] dac_dat_o,
  input logic                            dac_sel_o
);

  // channel alternates on every cycle out of reset
  sel_toggle: assert property (@(posedge adc_clk) disable iff (top_rst)
    !top_rst |=> dac_sel_o != $past(dac_sel_o))
    else $error("dac_sel_o held its value for two cycles");

  // done only drops on an arm
  done_release: assert property (@(posedge adc_clk) disable iff (top_rst)
    $fell(done_o) |-> $past(arm_i))
    else $error("done_o fell without an arm pulse");

  // midscale held while reset is high
  dac_reset_code: assert property (@(negedge adc_clk)
    top_rst |-> dac_dat_o == rp_sample_pkg::DAC_RESET_CODE)
    else $error("dac_dat_o left midscale during reset");

endmodule : rp_top_assertions

bind rp_top rp_top_assertions u_assertions (
  .adc_clk   (adc_clk  ),
  .top_rst   (top_rst  ),
  .arm_i     (arm_i    ),
  .done_o    (done_o   ),
  .dac_dat_o (dac_dat_o),
  .dac_sel_o (dac_sel_o)
);

// ==== verification/rp_top_tb.sv ====
////////////////////
// top level testbench
// table driven checks of the DAC bus, the
// ADC capture path, loop mode and PDM
////////////////////

`timescale 1ns/1ps

module rp_top_tb;

  localparam int NUM_ROWS     = 6;
  // cycles allowed from arm to done
  localparam int DONE_TIMEOUT = 200;

  // one stimulus row with its expected responses
  typedef struct packed {
    logic [rp_sample_pkg::NUM_ADC_CH-1:0][rp_sample_pkg::ADC_W-1:0] adc;
    logic [rp_sample_pkg::NUM_DAC_CH-1:0][rp_sample_pkg::DAC_W-1:0] gen;
    logic [rp_sample_pkg::NUM_ADC_CH-1:0]                           loop;
    logic [rp_ctrl_pkg::PDM_CHN-1:0][rp_ctrl_pkg::PDM_W-1:0]        pdm;
    logic [rp_sample_pkg::NUM_ADC_CH-1:0][rp_sample_pkg::ADC_W-1:0] exp_samp;
    logic [rp_sample_pkg::NUM_DAC_CH-1:0][rp_sample_pkg::DAC_W-1:0] exp_dac;
  } row_t;

  logic adc_clk = 1'b0;
  logic top_rst;
  logic [rp_sample_pkg::NUM_ADC_CH-1:0][rp_sample_pkg::ADC_W-1:0] adc_dat_i;
  logic [rp_sample_pkg::NUM_DAC_CH-1:0][rp_sample_pkg::DAC_W-1:0] gen_dat_i;
  logic [rp_sample_pkg::NUM_ADC_CH-1:0]                           loop_sel_i;
  logic                                                           arm_i;
  logic                                                           rd_ch_i;
  logic [rp_ctrl_pkg::CAP_AW-1:0]                                 rd_addr_i;
  rp_sample_pkg::adc_sample_t                                     rd_dat_o;
  logic                                                           done_o;
  logic [rp_sample_pkg::DAC_W-1:0]                                dac_dat_o;
  logic                                                           dac_sel_o;
  logic [rp_ctrl_pkg::PDM_CHN-1:0][rp_ctrl_pkg::PDM_W-1:0]        pdm_lvl_i;
  logic [rp_ctrl_pkg::PDM_CHN-1:0]                                pdm_o;

  row_t        tbl [NUM_ROWS];
  // random source state
  logic [15:0] lfsr_q = 16'd54;
  // channel expected on the DAC bus, low after reset
  logic        dac_ch_q = 1'b0;

  // 40 ns period
  always #20 adc_clk = ~adc_clk;

  // one channel per edge once reset is released
  always @(posedge adc_clk) begin
    if (!top_rst) begin
      dac_ch_q <= ~dac_ch_q;
    end
  end

  rp_top u_dut (
    .adc_clk    (adc_clk   ),
    .top_rst    (top_rst   ),
    .adc_dat_i  (adc_dat_i ),
    .gen_dat_i  (gen_dat_i ),
    .loop_sel_i (loop_sel_i),
    .arm_i      (arm_i     ),
    .rd_ch_i    (rd_ch_i   ),
    .rd_addr_i  (rd_addr_i ),
    .rd_dat_o   (rd_dat_o  ),
    .done_o     (done_o    ),
    .dac_dat_o  (dac_dat_o ),
    .dac_sel_o  (dac_sel_o ),
    .pdm_lvl_i  (pdm_lvl_i ),
    .pdm_o      (pdm_o     )
  );

  ////////////////////
  // reference rules
  ////////////////////

  // negative slope offset binary, sign bit kept
  function automatic logic [15:0] adc_to_twos(input logic [15:0] raw);
    return {raw[15], ~raw[14:0]};
  endfunction

  // sign extended then shifted by two, top bits drop out
  function automatic logic [15:0] gen_to_loop(input logic [13:0] g);
    return {g, 2'b00};
  endfunction

  // DAC offset code
  function automatic logic [13:0] gen_to_offset(input logic [13:0] g);
    return {g[13], ~g[12:0]};
  endfunction

  // galois LFSR, one step per bit
  function automatic logic lfsr_step();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 16'hB400;
    end
    return b;
  endfunction

  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[14:0], lfsr_step()};
    end
    return val;
  endfunction

  ////////////////////
  // stimulus table
  ////////////////////

  task automatic build_table();
    // corner rows first
    tbl[0].adc  = {16'hFFFF, 16'h0000};
    tbl[0].gen  = {14'h3FFF, 14'h0000};
    tbl[0].loop = 2'b00;
    tbl[0].pdm  = {8'd128, 8'd1, 8'd255, 8'd0};
    tbl[1].adc  = {16'h7FFF, 16'h8000};
    tbl[1].gen  = {14'h2000, 14'h1FFF};
    tbl[1].loop = 2'b01;
    tbl[1].pdm  = {8'd2, 8'd254, 8'd200, 8'd37};
    tbl[2].adc  = {16'hC0DE, 16'h1234};
    tbl[2].gen  = {14'h3210, 14'h0ABC};
    tbl[2].loop = 2'b10;
    tbl[2].pdm  = {8'd99, 8'd17, 8'd170, 8'd85};
    // random fill for the rest
    for (int r = 3; r < NUM_ROWS; r++) begin
      for (int c = 0; c < 2; c++) begin
        tbl[r].adc[c] = random_bits(16);
        tbl[r].gen[c] = 14'(random_bits(14));
      end
      tbl[r].loop = 2'(random_bits(2));
      for (int c = 0; c < 4; c++) begin
        tbl[r].pdm[c] = 8'(random_bits(8));
      end
    end
    // expected columns
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < 2; c++) begin
        if (tbl[r].loop[c]) begin
          tbl[r].exp_samp[c] = gen_to_loop(tbl[r].gen[c]);
        end else begin
          tbl[r].exp_samp[c] = adc_to_twos(tbl[r].adc[c]);
        end
        tbl[r].exp_dac[c] = gen_to_offset(tbl[r].gen[c]);
      end
    end
  endtask

  ////////////////////
  // checks and waits
  ////////////////////

  task automatic compare_value(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic wait_for_done();
    int n;
    for (n = 0; n < DONE_TIMEOUT && done_o !== 1'b1; n++) begin
      @(negedge adc_clk);
    end
    if (done_o !== 1'b1) begin
      $display("TESTS FAILED");
      $fatal(1, "capture did not finish, done_o stayed low after arm");
    end
  endtask

  task automatic apply_row(input int r);
    @(posedge adc_clk);
    adc_dat_i  <= tbl[r].adc;
    gen_dat_i  <= tbl[r].gen;
    loop_sel_i <= tbl[r].loop;
    pdm_lvl_i  <= tbl[r].pdm;
  endtask

  // two register stages to the DAC bus
  task automatic check_dac_bus(input int r);
    repeat (2) @(posedge adc_clk);
    for (int k = 0; k < 4; k++) begin
      @(negedge adc_clk);
      compare_value(16'(dac_sel_o), 16'(dac_ch_q),
                    $sformatf("row %0d dac select", r));
      compare_value(16'(dac_dat_o), 16'(tbl[r].exp_dac[dac_ch_q]),
                    $sformatf("row %0d dac channel %0d", r, dac_ch_q));
    end
  endtask

  task automatic run_capture(input int r);
    @(negedge adc_clk);
    // re-arm case, previous capture still flagged
    if (r > 0) begin
      compare_value(16'(done_o), 16'd1, $sformatf("row %0d done before arm", r));
    end
    @(posedge adc_clk);
    arm_i <= 1'b1;
    @(posedge adc_clk);
    arm_i <= 1'b0;
    @(negedge adc_clk);
    compare_value(16'(done_o), 16'd0, $sformatf("row %0d done cleared by arm", r));
    wait_for_done();
  endtask

  task automatic check_capture(input int r);
    for (int c = 0; c < 2; c++) begin
      for (int a = 0; a < rp_ctrl_pkg::CAP_DEPTH; a++) begin
        @(posedge adc_clk);
        rd_ch_i   <= 1'(c);
        rd_addr_i <= 5'(a);
        // one cycle read latency
        @(posedge adc_clk);
        @(negedge adc_clk);
        compare_value(rd_dat_o, tbl[r].exp_samp[c],
                      $sformatf("row %0d capture ch %0d addr %0d", r, c, a));
      end
    end
  endtask

  // pulses in any 255 cycle window equal the level
  task automatic count_pdm_pulses(input int r);
    int cnt [4];
    for (int c = 0; c < 4; c++) begin
      cnt[c] = 0;
    end
    for (int k = 0; k < 255; k++) begin
      @(negedge adc_clk);
      for (int c = 0; c < 4; c++) begin
        cnt[c] += int'(pdm_o[c]);
      end
    end
    for (int c = 0; c < 4; c++) begin
      compare_value(16'(cnt[c]), 16'(tbl[r].pdm[c]),
                    $sformatf("row %0d pdm channel %0d pulse count", r, c));
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    top_rst    = 1'b1;
    adc_dat_i  = '0;
    gen_dat_i  = '0;
    loop_sel_i = '0;
    arm_i      = 1'b0;
    rd_ch_i    = 1'b0;
    rd_addr_i  = '0;
    pdm_lvl_i  = '0;
    build_table();
    repeat (2) @(posedge adc_clk);
    top_rst <= 1'b0;
    // reset values before the first active edge
    @(negedge adc_clk);
    compare_value(16'(dac_dat_o), 16'd8191, "dac_dat_o after reset");
    compare_value(16'(dac_sel_o), 16'd0, "dac_sel_o after reset");
    compare_value(16'(done_o), 16'd0, "done_o after reset");
    compare_value(16'(pdm_o), 16'd0, "pdm_o after reset");
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
      check_dac_bus(r);
      run_capture(r);
      check_capture(r);
      count_pdm_pulses(r);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule : rp_top_tb
